// File: l2_controller.f
design/l2_pkg.sv
design/l2_tag_store.sv
design/l2_lru.sv
design/l2_fsm.sv
design/l2_controller.sv
testbench/l2_controller_properties.sv
testbench/l2_controller_tb.sv

// File: Makefile
TOP = l2_controller_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f l2_controller.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f l2_controller.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: testbench/l2_controller_tb.sv
`timescale 1ns/1ps

module l2_controller_tb;

    import l2_pkg::*;

    typedef logic [26:0] cmd_t;   // write flag, tag, index

    localparam int max_cycles = 3000;   // 80 accesses of up to ~20 cycles plus reset

    logic     clk;
    logic     nrst;
    l1_req_t  req;
    logic     flush;
    logic     mem_ready;
    l1_resp_t resp;
    mem_req_t mem_req;

    integer   seed = 17543;
    int       cycle_count = 0;
    cmd_t     mem_log [$];
    bit       last_wb;

    // reference model of the tag side
    tag_t       m_tag   [num_sets][num_ways];
    bit         m_valid [num_sets][num_ways];
    bit         m_dirty [num_sets][num_ways];
    logic [1:0] m_age   [num_sets][num_ways];

    l2_controller l2_controller_inst (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .flush     (flush),
        .mem_ready (mem_ready),
        .resp      (resp),
        .mem_req   (mem_req)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= max_cycles)
        begin
            $display("Errors found");
            $fatal(1, "timeout, the run went past %0d cycles", max_cycles);
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // answers each command after 0 to 5 cycles
    task automatic serve_memory();
        int delay;
        forever
        begin
            @(negedge clk);
            if (mem_req.read || mem_req.write)
            begin
                mem_log.push_back({mem_req.write, mem_req.tag, mem_req.index});
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                mem_ready = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
            end
        end
    endtask

    function automatic bit lookup_tag(input tag_t tag, input index_t idx, output way_t way);
        way = 2'd0;
        for (int w = 0; w < num_ways; w++)
            if (m_valid[idx][w] && m_tag[idx][w] == tag)
            begin
                way = way_t'(w);
                return 1'b1;
            end
        return 1'b0;
    endfunction

    function automatic way_t pick_victim(input index_t idx);
        for (int w = 0; w < num_ways; w++)
            if (!m_valid[idx][w])
                return way_t'(w);
        for (int w = 0; w < num_ways; w++)
            if (m_age[idx][w] == 2'd3)
                return way_t'(w);
        return 2'd0;
    endfunction

    function automatic void update_ages(input index_t idx, input way_t way);
        logic [1:0] old_age;
        old_age = m_age[idx][way];
        for (int w = 0; w < num_ways; w++)
            if (w == int'(way))
                m_age[idx][w] = 2'd0;
            else if (m_age[idx][w] < old_age)
                m_age[idx][w] = m_age[idx][w] + 2'd1;
    endfunction

    function automatic void invalidate_lines();
        for (int s = 0; s < num_sets; s++)
            for (int w = 0; w < num_ways; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
    endfunction

    // one L1 request checked against the model
    task automatic access(input bit is_write, input tag_t tag, input index_t idx,
                          output bit was_hit, output way_t way);
        cmd_t exp_cmds [$];
        way_t exp_way;
        bit   exp_hit;
        int   latency;
        int   refills;
        way_t refill_way;

        exp_hit = lookup_tag(tag, idx, exp_way);
        if (!exp_hit)
        begin
            exp_way = pick_victim(idx);
            if (m_dirty[idx][exp_way])
                exp_cmds.push_back({1'b1, m_tag[idx][exp_way], idx});   // old line out first
            exp_cmds.push_back({1'b0, tag, idx});
        end

        @(negedge clk);
        mem_log.delete();
        req.read   = !is_write;
        req.write  = is_write;
        req.tag    = tag;
        req.index  = idx;
        latency    = 0;
        refills    = 0;
        refill_way = 2'd0;
        do
        begin
            @(negedge clk);
            latency++;
            if (resp.refill)
            begin
                refills++;
                refill_way = resp.way;
            end
        end while (!resp.ready);
        req = '0;

        was_hit = (refills == 0);
        way     = resp.way;
        last_wb = 1'b0;
        foreach (mem_log[i])
            if (mem_log[i][26])
                last_wb = 1'b1;

        check(32'(way), 32'(exp_way), "ready way");
        check(32'(resp.update), 32'(is_write), "update strobe");
        check(refills, exp_hit ? 0 : 1, "refill pulses");
        if (exp_hit)
            check(latency, 2, "hit latency");
        else
            check(32'(refill_way), 32'(exp_way), "refill way");
        check(mem_log.size(), exp_cmds.size(), "memory command count");
        foreach (exp_cmds[i])
            check(32'(mem_log[i]), 32'(exp_cmds[i]), "memory command");

        if (!exp_hit)
        begin
            m_tag[idx][exp_way]   = tag;
            m_valid[idx][exp_way] = 1'b1;
            m_dirty[idx][exp_way] = 1'b0;
        end
        update_ages(idx, exp_way);
        if (is_write)
            m_dirty[idx][exp_way] = 1'b1;
    endtask

    task automatic cold_miss_test();
        bit   h;
        way_t w;
        access(1'b0, 18'h3a5a5, 8'd5, h, w);
        check(32'(h), 0, "cold read is a miss");
        check(32'(w), 0, "cold read fills way 0");
    endtask

    task automatic hit_timing_test();
        bit   h;
        way_t w;
        access(1'b0, 18'h3a5a5, 8'd5, h, w);
        check(32'(h), 1, "read hit");
        check(32'(w), 0, "read hit way");
        access(1'b1, 18'h3a5a5, 8'd5, h, w);
        check(32'(h), 1, "write hit");
    endtask

    task automatic lru_eviction_test();
        bit   h;
        way_t w;
        for (int i = 0; i < 4; i++)
        begin
            access(1'b0, tag_t'(18'h01000 + i), 8'd9, h, w);
            check(32'(w), i, "fill order");
        end
        access(1'b0, 18'h01001, 8'd9, h, w);
        access(1'b0, 18'h01000, 8'd9, h, w);
        access(1'b0, 18'h01004, 8'd9, h, w);   // way 2 is the oldest by now
        check(32'(h), 0, "fifth tag misses");
        check(32'(w), 2, "LRU victim way");
    endtask

    task automatic write_back_test();
        bit   h;
        way_t w;
        for (int i = 0; i < 4; i++)
            access(1'b0, tag_t'(18'h02000 + i), 8'd12, h, w);
        access(1'b1, 18'h02000, 8'd12, h, w);   // way 0 dirty
        for (int i = 1; i < 4; i++)
            access(1'b0, tag_t'(18'h02000 + i), 8'd12, h, w);
        access(1'b0, 18'h02004, 8'd12, h, w);
        check(32'(last_wb), 1, "dirty victim written back");
        check(32'(w), 0, "dirty way refilled");
    endtask

    task automatic flush_test();
        bit   h;
        way_t w;
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        invalidate_lines();
        access(1'b0, 18'h3a5a5, 8'd5, h, w);
        check(32'(h), 0, "miss after flush");
        check(32'(last_wb), 0, "no write-back after flush");
    endtask

    task automatic random_test();
        bit     is_write;
        tag_t   tag;
        index_t idx;
        bit     h;
        way_t   w;
        for (int i = 0; i < 60; i++)
        begin
            idx      = index_t'(20 + $unsigned($random(seed)) % 3);
            tag      = tag_t'(18'h04000 + $unsigned($random(seed)) % 6);   // 6 tags over 4 ways
            is_write = 1'($unsigned($random(seed)) % 2);
            access(is_write, tag, idx, h, w);
        end
    endtask

    initial serve_memory();

    initial
    begin
        req       = '0;
        flush     = 1'b0;
        mem_ready = 1'b0;
        nrst      = 1'b0;
        invalidate_lines();
        for (int s = 0; s < num_sets; s++)
            for (int w = 0; w < num_ways; w++)
            begin
                m_tag[s][w] = '0;
                m_age[s][w] = 2'(w);
            end
        repeat (10) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        cold_miss_test();
        hit_timing_test();
        lru_eviction_test();
        write_back_test();
        flush_test();
        random_test();

        $display("No errors");
        $finish;
    end

endmodule

// File: testbench/l2_controller_properties.sv
`timescale 1ns/1ps

module l2_controller_properties (
    input logic             clk,
    input logic             nrst,
    input l2_pkg::l1_resp_t resp,
    input l2_pkg::mem_req_t mem_req,
    input logic             mem_ready
);

    a_read_write_exclusive: assert property (
        @(posedge clk) disable iff (!nrst) !(mem_req.read && mem_req.write))
        else $error("memory read and write high together");

    a_ready_one_cycle: assert property (
        @(posedge clk) disable iff (!nrst) resp.ready |=> !resp.ready)
        else $error("ready high for two cycles running");

    // command held until memory takes it
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!nrst)
        (mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req))
        else $error("memory command changed before mem_ready");

    a_reset_quiet: assert property (
        @(posedge clk) $rose(nrst) |-> !resp.ready && !resp.update && !resp.refill
            && !mem_req.read && !mem_req.write)
        else $error("outputs not low after reset");

endmodule

bind l2_controller l2_controller_properties u_properties (
    .clk       (clk),
    .nrst      (nrst),
    .resp      (resp),
    .mem_req   (mem_req),
    .mem_ready (mem_ready)
);

// File: design/l2_controller.sv
`timescale 1ns/1ps

module l2_controller (
    input  logic              clk,
    input  logic              nrst,
    input  l2_pkg::l1_req_t   req,
    input  logic              flush,
    input  logic              mem_ready,
    output l2_pkg::l1_resp_t  resp,
    output l2_pkg::mem_req_t  mem_req
);

    import l2_pkg::*;

    logic     hit;
    way_t     hit_way;
    way_vec_t set_valid;
    tag_t     victim_tag;
    logic     victim_dirty;
    way_t     victim_way;
    logic     fill;
    way_t     fill_way;
    logic     write_hit;
    logic     clear_all;
    logic     touch;

    l2_tag_store u_tag_store (
        .clk          (clk),
        .nrst         (nrst),
        .index        (req.index),
        .tag          (req.tag),
        .victim_way   (victim_way),
        .fill         (fill),
        .fill_way     (fill_way),
        .write_hit    (write_hit),
        .clear_all    (clear_all),
        .hit          (hit),
        .hit_way      (hit_way),
        .set_valid    (set_valid),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    l2_lru u_lru (
        .clk        (clk),
        .nrst       (nrst),
        .index      (req.index),
        .touch      (touch),
        .hit_way    (hit_way),
        .set_valid  (set_valid),
        .victim_way (victim_way)
    );

    l2_fsm u_fsm (
        .clk          (clk),
        .nrst         (nrst),
        .req          (req),
        .flush        (flush),
        .mem_ready    (mem_ready),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .resp         (resp),
        .mem_req      (mem_req),
        .fill         (fill),
        .fill_way     (fill_way),
        .write_hit    (write_hit),
        .clear_all    (clear_all),
        .touch        (touch)
    );

endmodule

// File: design/l2_fsm.sv
`timescale 1ns/1ps

module l2_fsm (
    input  logic              clk,
    input  logic              nrst,
    input  l2_pkg::l1_req_t   req,
    input  logic              flush,
    input  logic              mem_ready,
    input  logic              hit,
    input  l2_pkg::way_t      hit_way,
    input  l2_pkg::way_t      victim_way,
    input  l2_pkg::tag_t      victim_tag,
    input  logic              victim_dirty,
    output l2_pkg::l1_resp_t  resp,
    output l2_pkg::mem_req_t  mem_req,
    output logic              fill,
    output l2_pkg::way_t      fill_way,
    output logic              write_hit,
    output logic              clear_all,
    output logic              touch
);

    import l2_pkg::*;

    typedef enum logic [1:0] {
        s_idle       = 2'b00,
        s_compare    = 2'b01,
        s_write_back = 2'b10,
        s_allocate   = 2'b11
    } state_t;

    state_t state;
    way_t   way_q;      // victim latched once at the miss

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state   <= s_idle;
            way_q   <= '0;
            resp    <= '0;
            mem_req <= '0;
        end
        else
        begin
            // L1 strobes are single-cycle
            resp.ready  <= 1'b0;
            resp.update <= 1'b0;
            resp.refill <= 1'b0;

            case (state)
                s_idle:
                begin
                    if (req.read || req.write)
                        state <= s_compare;
                end

                s_compare:
                begin
                    if (hit)
                    begin
                        resp.ready  <= 1'b1;
                        resp.update <= req.write;
                        resp.way    <= hit_way;
                        state       <= s_idle;
                    end
                    else
                    begin
                        way_q         <= victim_way;
                        mem_req.index <= req.index;
                        if (victim_dirty)
                        begin
                            mem_req.write <= 1'b1;
                            mem_req.tag   <= victim_tag;   // old line goes out first
                            state         <= s_write_back;
                        end
                        else
                        begin
                            mem_req.read <= 1'b1;
                            mem_req.tag  <= req.tag;
                            state        <= s_allocate;
                        end
                    end
                end

                s_write_back:
                begin
                    if (mem_ready)
                    begin
                        mem_req.write <= 1'b0;
                        mem_req.read  <= 1'b1;
                        mem_req.tag   <= req.tag;
                        state         <= s_allocate;
                    end
                end

                s_allocate:
                begin
                    if (mem_ready)
                    begin
                        mem_req.read <= 1'b0;
                        resp.refill  <= 1'b1;
                        resp.way     <= way_q;
                        state        <= s_compare;   // lookup again which now hits
                    end
                end

                default:
                begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // array strobes act on the edge that ends the current state
    assign touch     = (state == s_compare) && hit;
    assign write_hit = (state == s_compare) && hit && req.write;
    assign fill      = (state == s_allocate) && mem_ready;
    assign fill_way  = way_q;
    assign clear_all = (state == s_idle) && flush;

endmodule

// File: design/l2_lru.sv
`timescale 1ns/1ps

module l2_lru (
    input  logic              clk,
    input  logic              nrst,
    input  l2_pkg::index_t    index,
    input  logic              touch,
    input  l2_pkg::way_t      hit_way,
    input  l2_pkg::way_vec_t  set_valid,
    output l2_pkg::way_t      victim_way
);

    import l2_pkg::*;

    // one 2-bit age per way and set where 0 is most recent
    logic [num_sets-1:0][num_ways-1:0][1:0] age_q;
    logic [num_ways-1:0][1:0]               set_age;
    logic [num_ways-1:0][1:0]               next_age;
    logic [1:0]                             hit_age;

    assign set_age = age_q[index];
    assign hit_age = set_age[hit_way];

    // accessed way goes to 0 and younger ways age by one
    always_comb
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            if (way_t'(w) == hit_way)
                next_age[w] = 2'd0;
            else if (set_age[w] < hit_age)
                next_age[w] = set_age[w] + 2'd1;
            else
                next_age[w] = set_age[w];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < num_sets; s++)
            begin
                for (int w = 0; w < num_ways; w++)
                begin
                    age_q[s][w] <= 2'(w);   // way n starts at age n
                end
            end
        end
        else if (touch)
        begin
            age_q[index] <= next_age;
        end
    end

    // lowest invalid way first or else the oldest
    always_comb
    begin
        victim_way = '0;
        for (int w = num_ways - 1; w >= 0; w--)
        begin
            if (set_age[w] == 2'd3)
                victim_way = way_t'(w);
        end
        for (int w = num_ways - 1; w >= 0; w--)
        begin
            if (!set_valid[w])
                victim_way = way_t'(w);
        end
    end

endmodule

// File: design/l2_tag_store.sv
`timescale 1ns/1ps

module l2_tag_store (
    input  logic              clk,
    input  logic              nrst,
    input  l2_pkg::index_t    index,
    input  l2_pkg::tag_t      tag,
    input  l2_pkg::way_t      victim_way,
    input  logic              fill,
    input  l2_pkg::way_t      fill_way,
    input  logic              write_hit,
    input  logic              clear_all,
    output logic              hit,
    output l2_pkg::way_t      hit_way,
    output l2_pkg::way_vec_t  set_valid,
    output l2_pkg::tag_t      victim_tag,
    output logic              victim_dirty
);

    import l2_pkg::*;

    tag_t                     tag_q [num_sets][num_ways];
    way_vec_t [num_sets-1:0]  valid_q;
    way_vec_t [num_sets-1:0]  dirty_q;

    // tag array written on refill only
    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            tag_q[index][fill_way] <= tag;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid_q <= '0;
        end
        else if (clear_all)
        begin
            valid_q <= '0;
        end
        else if (fill)
        begin
            valid_q[index][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            dirty_q <= '0;
        end
        else if (clear_all)
        begin
            dirty_q <= '0;
        end
        else if (fill)
        begin
            dirty_q[index][fill_way] <= 1'b0;   // fresh line from memory
        end
        else if (write_hit)
        begin
            dirty_q[index][hit_way] <= 1'b1;
        end
    end

    // compare against all four ways of the set
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++)
        begin
            if (valid_q[index][w] && (tag_q[index][w] == tag))
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign set_valid    = valid_q[index];
    assign victim_tag   = tag_q[index][victim_way];   // address of the write-back
    assign victim_dirty = dirty_q[index][victim_way];

endmodule

// File: design/l2_pkg.sv
package l2_pkg;

    // cache geometry
    localparam int tag_w    = 18;
    localparam int index_w  = 8;
    localparam int num_ways = 4;
    localparam int num_sets = 1 << index_w;

    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [1:0]          way_t;
    typedef logic [num_ways-1:0] way_vec_t;  // one bit per way

    // request from L1 held until ready
    typedef struct packed {
        logic   read;
        logic   write;
        tag_t   tag;
        index_t index;
    } l1_req_t;

    // strobes back to L1 and the data array
    typedef struct packed {
        logic ready;
        logic update;   // data array takes the L1 data on a write hit
        logic refill;   // data array takes the memory data
        way_t way;
    } l1_resp_t;

    // command to memory held until mem_ready
    typedef struct packed {
        logic   read;
        logic   write;
        tag_t   tag;
        index_t index;
    } mem_req_t;

endpackage
